// File: hw/led_matrix_pkg.sv
//**************************************************************************
// LED matrix scan sequencer package
// Timing constants, counter opcodes, FSM state codes and the DAC word
//**************************************************************************

package led_matrix_pkg;

  // Timing kept short for simulation
  localparam int unsigned LOCKOUT_CYCLES  = 20;  // Button ignored after a start
  localparam int unsigned DWELL_CYCLES    = 3;   // Hold time per position
  localparam int unsigned SCK_HALF_CYCLES = 4;   // Serial clock half period

  // Counter widths derived from the timing values
  localparam int unsigned LOCK_W  = $clog2(LOCKOUT_CYCLES + 1);
  localparam int unsigned DWELL_W = $clog2(DWELL_CYCLES + 1);
  localparam int unsigned SCK_W   = $clog2(SCK_HALF_CYCLES);

  // Row and column counter opcodes
  localparam logic [1:0] CNT_HOLD = 2'b00;
  localparam logic [1:0] CNT_CLR  = 2'b01;
  localparam logic [1:0] CNT_INC  = 2'b10;
  localparam logic [1:0] CNT_MAX  = 2'd3;  // Last row or column index

  // Scan FSM state codes
  localparam logic [2:0] ST_IDLE     = 3'd0;
  localparam logic [2:0] ST_WRITE    = 3'd1;
  localparam logic [2:0] ST_WAIT_DAC = 3'd2;
  localparam logic [2:0] ST_DWELL    = 3'd3;
  localparam logic [2:0] ST_STEP     = 3'd4;

  // DAC command seen as raw shift bits or as control plus level
  typedef union packed {
    logic [15:0] raw;
    struct packed {
      logic [3:0]  ctrl;
      logic [11:0] level;
    } fields;
  } dac_word_u;

  localparam logic [3:0]  DAC_CTRL  = 4'b0011;          // Channel A
  localparam logic [11:0] DAC_LEVEL = 12'b111010001011; // About 3 V

  localparam dac_word_u DAC_WORD = dac_word_u'({DAC_CTRL, DAC_LEVEL});

endpackage

// File: hw/single_tick.sv
//**************************************************************************
// Push button start pulse generator
// Synchronizes the button, emits one pulse per press, then locks out
//**************************************************************************

module single_tick
  import led_matrix_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic button_i,
  output logic start_o
);

  logic              btn_meta_q;
  logic              btn_sync_q;
  logic              btn_prev_q;
  logic [LOCK_W-1:0] lock_cnt_q;
  logic              rise;
  logic              locked;

  assign rise   = btn_sync_q & ~btn_prev_q;
  assign locked = (lock_cnt_q != '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      btn_meta_q <= 1'b0;
      btn_sync_q <= 1'b0;
      btn_prev_q <= 1'b0;
      lock_cnt_q <= '0;
      start_o    <= 1'b0;
    end else begin
      btn_meta_q <= button_i;  // Two flop synchronizer
      btn_sync_q <= btn_meta_q;
      btn_prev_q <= btn_sync_q;
      start_o    <= rise & ~locked;
      if (rise && !locked) begin
        lock_cnt_q <= LOCK_W'(LOCKOUT_CYCLES);  // Open lockout window
      end else if (locked) begin
        lock_cnt_q <= lock_cnt_q - 1'b1;
      end
    end
  end

  // One cycle wide start
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    start_o |=> !start_o);

endmodule

// File: hw/fsm_led_matrix.sv
//**************************************************************************
// Scan state machine
// Steps through the 16 positions: DAC write, dwell, then counter update
//**************************************************************************

module fsm_led_matrix
  import led_matrix_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       start_i,
  input  logic       eodac_i,
  input  logic       z_i,
  input  logic [1:0] count_col_i,
  input  logic [1:0] count_row_i,
  output logic       stdac_o,
  output logic       en_o,
  output logic       eos_o,
  output logic [1:0] opcol_o,
  output logic [1:0] oprow_o
);

  logic [2:0] state_q;
  logic [2:0] state_d;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    stdac_o = 1'b0;
    en_o    = 1'b0;
    eos_o   = 1'b0;
    opcol_o = CNT_HOLD;
    oprow_o = CNT_HOLD;

    case (state_q)
      ST_IDLE: begin
        if (start_i) begin
          state_d = ST_WRITE;
        end
      end

      ST_WRITE: begin
        stdac_o = 1'b1;  // Kick off one DAC frame
        state_d = ST_WAIT_DAC;
      end

      ST_WAIT_DAC: begin
        if (eodac_i) begin
          state_d = ST_DWELL;
        end
      end

      ST_DWELL: begin
        en_o = 1'b1;
        if (z_i) begin
          state_d = ST_STEP;
        end
      end

      ST_STEP: begin
        // Row-major advance
        if (count_col_i != CNT_MAX) begin
          opcol_o = CNT_INC;
          state_d = ST_WRITE;
        end else if (count_row_i != CNT_MAX) begin
          opcol_o = CNT_CLR;  // Wrap to next row
          oprow_o = CNT_INC;
          state_d = ST_WRITE;
        end else begin
          opcol_o = CNT_CLR;
          oprow_o = CNT_CLR;
          eos_o   = 1'b1;  // Last position done
          state_d = ST_IDLE;
        end
      end

      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  // Dwell only ever follows a finished DAC frame
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(en_o) |-> $past(eodac_i));

  // No second strobe until the writer reports back
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stdac_o |=> (!stdac_o throughout eodac_i[->1]));

endmodule

// File: hw/spi_write_dac.sv
//**************************************************************************
// SPI DAC writer
// Shifts one 16-bit command word out on mosi, MSB first, write only
//**************************************************************************

module spi_write_dac
  import led_matrix_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      strw_i,
  input  dac_word_u din_i,
  output logic      mosi_o,
  output logic      sck_o,
  output logic      cs_o,
  output logic      eow_o
);

  dac_word_u        shreg_q;  // Shift register
  logic [SCK_W-1:0] div_q;
  logic [3:0]       bit_q;
  logic             cs_d_q;
  logic             half_done;

  assign half_done = (div_q == SCK_W'(SCK_HALF_CYCLES - 1));

  always_ff @(posedge clk_i) begin
    if (cs_o && strw_i) begin
      shreg_q <= din_i;
    end else if (!cs_o && half_done && sck_o) begin
      shreg_q.raw <= {shreg_q.raw[14:0], 1'b0};
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cs_o   <= 1'b1;
      sck_o  <= 1'b0;
      mosi_o <= 1'b0;
      div_q  <= '0;
      bit_q  <= '0;
      cs_d_q <= 1'b1;
      eow_o  <= 1'b0;
    end else begin
      cs_d_q <= cs_o;
      eow_o  <= cs_o & ~cs_d_q;  // Cycle after cs rises
      if (cs_o) begin
        if (strw_i) begin
          cs_o   <= 1'b0;
          sck_o  <= 1'b0;
          mosi_o <= din_i.raw[15];  // First bit ready during low half
          div_q  <= '0;
          bit_q  <= '0;
        end
      end else if (half_done) begin
        div_q <= '0;
        if (!sck_o) begin
          sck_o <= 1'b1;  // DAC samples here
        end else if (bit_q == 4'd15) begin
          sck_o  <= 1'b0;
          cs_o   <= 1'b1;  // Frame complete
          mosi_o <= 1'b0;
        end else begin
          sck_o  <= 1'b0;
          bit_q  <= bit_q + 4'd1;
          mosi_o <= shreg_q.raw[14];
        end
      end else begin
        div_q <= div_q + 1'b1;
      end
    end
  end

  // Serial clock parked low between frames
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cs_o |-> !sck_o);

  // Every frame end is reported once
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(cs_o) |=> eow_o ##1 !eow_o);

endmodule

// File: hw/timer.sv
//**************************************************************************
// Dwell timer
// Counts DWELL_CYCLES down while enabled, flags expiry
//**************************************************************************

module timer
  import led_matrix_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic en_i,
  output logic z_o
);

  logic [DWELL_W-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= DWELL_W'(DWELL_CYCLES);
    end else if (!en_i) begin
      cnt_q <= DWELL_W'(DWELL_CYCLES);  // Reload while idle
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign z_o = en_i & (cnt_q == '0);

  // Expiry needs the enable held for the full dwell
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    z_o |-> en_i && $past(en_i, DWELL_CYCLES));

endmodule

// File: hw/scan_counter.sv
//**************************************************************************
// Row or column position counter
// Two-bit index with hold, clear and increment opcodes
//**************************************************************************

module scan_counter
  import led_matrix_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic [1:0] opc_i,
  output logic [1:0] count_o
);

  logic [1:0] count_d;

  always_comb begin
    case (opc_i)
      CNT_CLR: count_d = 2'd0;
      CNT_INC: count_d = count_o + 2'd1;  // Wraps at 3
      default: count_d = count_o;         // Hold
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_o <= 2'd0;
    end else begin
      count_o <= count_d;
    end
  end

  // Never stepped past the last index
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (opc_i == CNT_INC) |-> (count_o != CNT_MAX));

endmodule

// File: hw/led_matrix_seq.sv
//**************************************************************************
// LED matrix scan sequencer, top level
// Button start, scan FSM, SPI DAC writer, dwell timer and position counters
//**************************************************************************

module led_matrix_seq
  import led_matrix_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       button_i,
  output logic       mosi_o,
  output logic       sck_o,
  output logic       cs_o,
  output logic       eos_o,
  output logic [1:0] count_col_o,
  output logic [1:0] count_row_o
);

  logic       start;
  logic       stdac;
  logic       eodac;
  logic       en;
  logic       z;
  logic [1:0] opcol;
  logic [1:0] oprow;

  single_tick u_single_tick (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .button_i (button_i),
    .start_o  (start)
  );

  fsm_led_matrix u_fsm (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .start_i     (start),
    .eodac_i     (eodac),
    .z_i         (z),
    .count_col_i (count_col_o),  // Fed back from the counters
    .count_row_i (count_row_o),
    .stdac_o     (stdac),
    .en_o        (en),
    .eos_o       (eos_o),
    .opcol_o     (opcol),
    .oprow_o     (oprow)
  );

  // Fixed command word
  spi_write_dac u_spi_write_dac (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .strw_i  (stdac),
    .din_i   (DAC_WORD),
    .mosi_o  (mosi_o),
    .sck_o   (sck_o),
    .cs_o    (cs_o),
    .eow_o   (eodac)
  );

  timer u_timer (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .en_i    (en),
    .z_o     (z)
  );

  scan_counter u_count_col (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .opc_i   (opcol),
    .count_o (count_col_o)
  );

  scan_counter u_count_row (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .opc_i   (oprow),
    .count_o (count_row_o)
  );

endmodule

// File: tb/clk_gen.sv
//**************************************************************************
// Testbench clock source
// Free running clock with a period of 4 time units
//**************************************************************************

module clk_gen (
  output logic clk_o
);

  localparam int unsigned HALF_PERIOD = 2;

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

endmodule

// File: tb/led_matrix_seq_tb.sv
//**************************************************************************
// LED matrix scan sequencer testbench
// Button stimulus, reference tracking and concurrent checks on SPI and scan
//**************************************************************************

module led_matrix_seq_tb
  import led_matrix_pkg::*;
();

  localparam int unsigned SEED        = 12782;
  localparam int unsigned N_SCANS     = 4;
  localparam int unsigned POS_CYCLES  = 150;  // Budget per position
  localparam int unsigned MAX_CYCLES  = 2 * N_SCANS * (16 * POS_CYCLES + 5 * LOCKOUT_CYCLES);
  localparam int unsigned START_BOUND = 8;    // Release to cs_o fall
  localparam logic [15:0] EXP_WORD    = {DAC_CTRL, DAC_LEVEL};

  logic        clk;
  logic        rst_n;
  logic        button;
  logic        mosi;
  logic        sck;
  logic        cs;
  logic        eos;
  logic [1:0]  count_col;
  logic [1:0]  count_row;

  logic        scan_armed;  // High while the stimulus expects a scan
  logic        sck_q;
  logic        cs_q;
  logic [1:0]  col_q;
  logic [1:0]  row_q;
  logic [1:0]  nxt_col;
  logic [1:0]  nxt_row;
  logic        pos_changed;
  logic [4:0]  rise_cnt;
  logic        exp_bit;
  int unsigned half_len;
  int unsigned cs_high_len;
  int unsigned frames_at_pos;
  int unsigned frames_in_scan;
  int unsigned cycle_cnt;
  int unsigned errors;
  int unsigned errors_before;
  int unsigned n_tests;
  int unsigned n_failed;

  clk_gen u_clk_gen (
    .clk_o (clk)
  );

  led_matrix_seq led_matrix_seq_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .button_i    (button),
    .mosi_o      (mosi),
    .sck_o       (sck),
    .cs_o        (cs),
    .eos_o       (eos),
    .count_col_o (count_col),
    .count_row_o (count_row)
  );

  // Row-major successor with the last position wrapping to the first
  assign {nxt_row, nxt_col} = {row_q, col_q} + 4'd1;
  assign pos_changed = (count_col != col_q) || (count_row != row_q);
  assign exp_bit = EXP_WORD[4'd15 - rise_cnt[3:0]];  // MSB first

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sck_q          <= 1'b0;
      cs_q           <= 1'b1;
      col_q          <= 2'd0;
      row_q          <= 2'd0;
      rise_cnt       <= '0;
      half_len       <= 0;
      cs_high_len    <= 0;
      frames_at_pos  <= 0;
      frames_in_scan <= 0;
    end else begin
      sck_q <= sck;
      cs_q  <= cs;
      col_q <= count_col;
      row_q <= count_row;
      if (cs_q && !cs) begin
        rise_cnt <= '0;  // Frame start
      end else if (sck && !sck_q) begin
        rise_cnt <= rise_cnt + 5'd1;
      end
      if ((cs_q && !cs) || (sck != sck_q)) begin
        half_len <= 1;
      end else begin
        half_len <= half_len + 1;
      end
      if (cs && !cs_q) begin
        cs_high_len <= 1;
      end else if (cs) begin
        cs_high_len <= cs_high_len + 1;
      end
      if (pos_changed) begin
        frames_at_pos <= 0;
      end else if (cs_q && !cs) begin
        frames_at_pos <= frames_at_pos + 1;
      end
      if (eos) begin
        frames_in_scan <= 0;
      end else if (cs_q && !cs) begin
        frames_in_scan <= frames_in_scan + 1;
      end
    end
  end

  task automatic value_error(input string name, input int unsigned expv,
                             input int unsigned actv);
    errors++;
    $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, expv, actv);
  endtask

  task automatic event_error(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  // Between scans everything stays parked
  idle_cs: assert property (@(posedge clk) disable iff (!rst_n) !scan_armed |-> cs)
    else value_error("cs_o", 32'd1, 32'($sampled(cs)));
  idle_sck: assert property (@(posedge clk) disable iff (!rst_n) !scan_armed |-> !sck)
    else value_error("sck_o", 32'd0, 32'($sampled(sck)));
  idle_eos: assert property (@(posedge clk) disable iff (!rst_n) !scan_armed |-> !eos)
    else value_error("eos_o", 32'd0, 32'($sampled(eos)));
  idle_col: assert property (@(posedge clk) disable iff (!rst_n)
    !scan_armed |-> count_col == 2'd0)
    else value_error("count_col_o", 32'd0, 32'($sampled(count_col)));
  idle_row: assert property (@(posedge clk) disable iff (!rst_n)
    !scan_armed |-> count_row == 2'd0)
    else value_error("count_row_o", 32'd0, 32'($sampled(count_row)));

  // SPI frame shape
  frame_bit: assert property (@(posedge clk) disable iff (!rst_n) $rose(sck) |-> mosi == exp_bit)
    else value_error("mosi_o", 32'($sampled(exp_bit)), 32'($sampled(mosi)));
  frame_half: assert property (@(posedge clk) disable iff (!rst_n)
    (sck != sck_q) |-> half_len == SCK_HALF_CYCLES)
    else value_error("sck_o half period", SCK_HALF_CYCLES, $sampled(half_len));
  frame_edges: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cs) |-> rise_cnt == 5'd16)
    else value_error("sck_o rising edges", 32'd16, 32'($sampled(rise_cnt)));
  frame_gap: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(cs) |-> cs_high_len > DWELL_CYCLES)
    else event_error("DAC frame started before the dwell time ended");

  // Scan order and end of scan
  order_col: assert property (@(posedge clk) disable iff (!rst_n)
    pos_changed |-> count_col == nxt_col)
    else value_error("count_col_o", 32'($sampled(nxt_col)), 32'($sampled(count_col)));
  order_row: assert property (@(posedge clk) disable iff (!rst_n)
    pos_changed |-> count_row == nxt_row)
    else value_error("count_row_o", 32'($sampled(nxt_row)), 32'($sampled(count_row)));
  one_frame: assert property (@(posedge clk) disable iff (!rst_n)
    pos_changed |-> frames_at_pos == 1)
    else value_error("DAC frames per position", 32'd1, $sampled(frames_at_pos));
  eos_frames: assert property (@(posedge clk) disable iff (!rst_n)
    eos |-> frames_in_scan == 16)
    else value_error("DAC frames per scan", 32'd16, $sampled(frames_in_scan));
  eos_pulse: assert property (@(posedge clk) disable iff (!rst_n) eos |=> !eos)
    else value_error("eos_o", 32'd0, 32'd1);
  eos_last: assert property (@(posedge clk) disable iff (!rst_n)
    (pos_changed && {row_q, col_q} == 4'hF) |-> $past(eos))
    else value_error("eos_o", 32'd1, 32'd0);

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("timeout, no result after %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic press_button(input int unsigned hold);
    button = 1'b1;
    repeat (hold) step();
    button = 1'b0;
  endtask

  // One accepted press plus optional presses that must be dropped
  task automatic run_scan(input bit rough);
    int unsigned waited;
    int unsigned gap;
    waited = 0;
    scan_armed = 1'b1;
    press_button(2);
    while (cs && waited < START_BOUND) begin
      step();
      waited++;
    end
    if (cs) begin
      event_error("no DAC frame started after an accepted press");
    end
    if (rough) begin
      press_button(2);  // Inside the lockout window while busy
      repeat (4) begin
        gap = 20 + $urandom_range(60);
        repeat (gap) step();
        press_button(2);  // Scan busy
      end
      // Last frame done, so this lockout outlasts eos_o
      while (!(count_col == CNT_MAX && count_row == CNT_MAX && !cs)) begin
        step();
      end
      while (!cs) begin
        step();
      end
      press_button(2);
    end
    while (!eos) begin
      step();
    end
    step();
    scan_armed = 1'b0;
    if (rough) begin
      press_button(2);  // Idle but still locked out
    end
  endtask

  task automatic end_test(input string name);
    n_tests++;
    if (errors == errors_before) begin
      $display("test %0d %s: passed", n_tests, name);
    end else begin
      n_failed++;
      $display("test %0d %s: failed, %0d errors", n_tests, name, errors - errors_before);
    end
    errors_before = errors;
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n      = 1'b0;
    button     = 1'b0;
    scan_armed = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;

    repeat (10) step();
    end_test("reset state");
    run_scan(1'b0);
    end_test("spi frames");
    run_scan(1'b0);
    end_test("scan order");
    run_scan(1'b0);
    repeat (4 * LOCKOUT_CYCLES) step();  // Quiet after eos_o
    end_test("end of scan");
    run_scan(1'b1);
    repeat (4 * LOCKOUT_CYCLES) step();
    end_test("press filtering");

    $display("tests: %0d run, %0d failed, %0d errors", n_tests, n_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: flist.f
hw/led_matrix_pkg.sv
hw/single_tick.sv
hw/fsm_led_matrix.sv
hw/spi_write_dac.sv
hw/timer.sv
hw/scan_counter.sv
hw/led_matrix_seq.sv
tb/clk_gen.sv
tb/led_matrix_seq_tb.sv

// File: Makefile
# Verilator flow for the LED matrix scan sequencer

TOP := led_matrix_seq_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "TEST FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log
